//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pcs_am_inserter
RTL_TOP   = pcs_am_inserter
FILELIST  = src.f
RTL_FILES = $(filter source/%,$(shell cat $(FILELIST)))
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = *** TEST FAILED ***

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_FILES)
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/am_inserter_tests.txt
# Alignment marker inserter test cases, one per line
# blocks seed_offset gap_pattern(hex, set bit = idle cycle) bad_headers(of 16) markers
5    0   00  0   1
16   1   00  0   2
17   2   00  0   2
40   3   00  0   3
48   4   55  0   4
33   5   81  0   3
64   6   0f  2   5
32   7   00  16  3
50   8   a5  4   4
31   9   3c  0   2
80   10  33  3   6
1    11  00  8   1
100  12  24  5   7

//--- sim/tb_pcs_am_inserter.sv
// Testbench for pcs_am_inserter with test file reader, reference model, output checker and timeout
`timescale 1ns/1ns

module tb_pcs_am_inserter;

   localparam int PERIOD_BLOCKS = 16;
   localparam logic [65:0] ERR_BLOCK = {{8{7'h1E}}, 8'h1E, 2'b01};

   logic        i_clock = 1'b0;
   logic        i_reset;
   logic        i_valid;
   logic [65:0] i_block;
   logic        o_ready;
   logic        o_valid;
   logic [65:0] o_block;

   int          t_blocks[$];
   int          t_seed[$];
   logic [7:0]  t_gap[$];
   int          t_rate[$];
   int          t_markers[$];
   logic [65:0] expect_q[$];     // Predicted output stream, in order
   logic [7:0]  model_acc;
   int          model_count;
   int          ready_low;       // Cycles in which the model still expects o_ready low
   logic [31:0] lcg_state;
   int          markers_seen = 0;
   int          value_errors = 0;
   int          other_errors = 0;
   int          cycle_count = 0;
   int          cycle_limit = 0;
   logic        tests_loaded;

   pcs_am_inserter DUT (
      .i_clock (i_clock),
      .i_reset (i_reset),
      .i_valid (i_valid),
      .i_block (i_block),
      .o_ready (o_ready),
      .o_valid (o_valid),
      .o_block (o_block)
   );

   always #50 i_clock = ~i_clock;

   // ============================================================
   // Reference model
   // ============================================================
   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // Lane k XORs bits 2+k+8j and the sync bits fold into lanes 3 and 4
   function automatic logic [7:0] bip_of(input logic [65:0] blk);
      logic [7:0]  p;
      logic [63:0] body;
      p = {3'b000, blk[1], blk[0], 3'b000};
      body = blk[65:2];
      for (int j = 0; j < 8; j++)
      begin
         p = p ^ body[7:0];
         body = body >> 8;
      end
      return p;
   endfunction

   function automatic logic [65:0] marker_with(input logic [7:0] bip);
      return {~bip, ~8'h47, ~8'h76, ~8'h90, bip, 8'h47, 8'h76, 8'h90, 2'b01};
   endfunction

   task automatic push_marker();
      expect_q.push_back(marker_with(model_acc));
      model_acc = bip_of(marker_with(model_acc));   // Next interval opens with this marker
   endtask

   task automatic push_data(input logic [65:0] blk);
      logic [65:0] out_blk;
      out_blk = (blk[1:0] == 2'b00 || blk[1:0] == 2'b11) ? ERR_BLOCK : blk;
      expect_q.push_back(out_blk);
      model_acc = model_acc ^ bip_of(out_blk);
      model_count++;
      if (model_count == PERIOD_BLOCKS)
      begin
         push_marker();
         model_count = 0;
         ready_low = 2;   // Due cycle and the marker slot
      end
   endtask

   task automatic draw_block(input int rate, output logic [65:0] blk);
      logic [31:0] hi;
      logic [31:0] lo;
      lcg_state = lcg_next(lcg_state);
      hi = lcg_state;
      lcg_state = lcg_next(lcg_state);
      lo = lcg_state;
      lcg_state = lcg_next(lcg_state);
      if (int'(lcg_state[31:28]) < rate)
         blk = {hi, lo, {2{lcg_state[27]}}};   // Header 00 or 11
      else
         blk = {hi, lo, lcg_state[26], ~lcg_state[26]};
   endtask

   // ============================================================
   // Checking
   // ============================================================
   task automatic check_value(input string name, input logic [65:0] actual,
                              input logic [65:0] expected);
      if (actual !== expected)
      begin
         $display("ERR %0t %s: got %h, expected %h", $time, name, actual, expected);
         value_errors++;
      end
   endtask

   // Advance one clock and compare whatever the DUT put out
   task automatic step_cycle();
      @(posedge i_clock);
      #1;
      if (!i_reset && o_valid)
      begin
         if (expect_q.size() == 0)
         begin
            $display("Output block %h at %0t was not expected", o_block, $time);
            other_errors++;
         end
         else
            check_value("o_block", o_block, expect_q.pop_front());
         if (o_block[25:0] == {24'h477690, 2'b01})
            markers_seen++;
      end
   endtask

   task automatic run_case(input int idx);
      logic [65:0] cur;
      logic [7:0]  gap;
      logic        have;
      int          sent;
      int          cyc;
      int          first_marker;
      cur = '0;
      gap = t_gap[idx];
      have = 1'b0;
      sent = 0;
      cyc = 0;
      first_marker = markers_seen;
      lcg_state = 32'hff76b7df + 32'(t_seed[idx]);
      i_reset = 1'b1;
      i_valid = 1'b0;
      repeat (16) step_cycle();
      i_reset = 1'b0;
      model_acc = '0;
      model_count = 0;
      ready_low = 1;   // Start slot
      push_marker();   // Slot straight after reset
      while (sent < t_blocks[idx])
      begin
         if (!have && !gap[3'(cyc)])
         begin
            draw_block(t_rate[idx], cur);
            have = 1'b1;
         end
         i_valid = have;
         i_block = cur;
         check_value("o_ready", 66'(o_ready), 66'(ready_low == 0));
         if (ready_low > 0)
            ready_low--;
         if (have && o_ready)
         begin
            push_data(cur);
            sent++;
            have = 1'b0;
         end
         step_cycle();
         cyc++;
      end
      i_valid = 1'b0;
      while (expect_q.size() != 0)
         step_cycle();
      repeat (2) step_cycle();
      check_value("marker_count", 66'(markers_seen - first_marker), 66'(t_markers[idx]));
   endtask

   task automatic load_tests();
      int         fd;
      int         n;
      int         seed;
      int         rate;
      int         markers;
      int         total;
      logic [7:0] gap;
      string      line;
      total = 0;
      fd = $fopen("sim/am_inserter_tests.txt", "r");
      if (fd != 0)
      begin
         while ($fgets(line, fd) != 0)
         begin
            if ($sscanf(line, "%d %d %h %d %d", n, seed, gap, rate, markers) == 5)
            begin
               t_blocks.push_back(n);
               t_seed.push_back(seed);
               t_gap.push_back(gap);
               t_rate.push_back(rate);
               t_markers.push_back(markers);
               total += n;
            end
         end
         $fclose(fd);
      end
      tests_loaded = (t_blocks.size() > 0);
      cycle_limit = 4 * total + 32 * t_blocks.size() + 100;   // Reset and drain per case
   endtask

   // ============================================================
   // Main sequence and watchdog
   // ============================================================
   initial
   begin
      i_reset = 1'b1;
      i_valid = 1'b0;
      i_block = '0;
      load_tests();
      if (!tests_loaded)
      begin
         $display("Could not read any test case from sim/am_inserter_tests.txt");
         $display("*** TEST FAILED ***");
         $finish;
      end
      else
      begin
         for (int k = 0; k < t_blocks.size(); k++)
            run_case(k);
         $display("Errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
         if (value_errors == 0 && other_errors == 0)
            $display("*** TEST PASSED ***");
         else
            $display("*** TEST FAILED ***");
         $finish;
      end
   end

   always @(posedge i_clock)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count > cycle_limit)
      begin
         $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
         $display("*** TEST FAILED ***");
         $finish;
      end
   end

endmodule

//--- source/am_block_builder.sv
// Module am_block_builder: stage 1 register choosing data, error block or marker template
`timescale 1ns/1ns

module am_block_builder
   import pcs_lane_pkg::*;
(
   input  logic               i_clock,
   input  logic               i_reset,
   input  logic               i_valid,
   input  logic               i_ready,
   input  logic [BLOCK_W-1:0] i_block,
   input  logic               i_send_marker,
   output logic               o_valid,
   output logic [BLOCK_W-1:0] o_block,
   output logic               o_is_marker
);

   logic accept;
   logic bad_header;

   assign accept     = i_valid && i_ready;
   assign bad_header = (i_block[1:0] != SH_DATA) && (i_block[1:0] != SH_CTRL);   // 00 or 11

   // Control bits
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         o_valid     <= 1'b0;
         o_is_marker <= 1'b0;
      end
      else
      begin
         o_valid     <= i_send_marker || accept;
         o_is_marker <= i_send_marker;
      end
   end

   // Payload
   always_ff @(posedge i_clock)
   begin
      if (i_send_marker)
      begin
         o_block <= AM_TEMPLATE;
      end
      else if (accept)
      begin
         o_block <= bad_header ? E_BLOCK : i_block;
      end
   end

endmodule

//--- source/am_ctrl_pkg.sv
// Package: marker inserter state type, marker period and timer width
package am_ctrl_pkg;

   // Inserter states
   typedef enum logic [1:0]
   {
      ST_START = 2'd0,   // Marker slot straight after reset
      ST_DATA  = 2'd1,
      ST_MARK  = 2'd2    // Periodic marker slot
   } am_state_t;

   // Data blocks between two markers, shortened for simulation
   localparam int AM_PERIOD = 16;

   // Wide enough to hold AM_PERIOD
   localparam int CNT_W = 5;

endpackage

//--- source/am_insert_fsm.sv
// Module am_insert_fsm with marker slot scheduling and upstream ready
`timescale 1ns/1ns

module am_insert_fsm
   import am_ctrl_pkg::*;
(
   input  logic i_clock,
   input  logic i_reset,
   input  logic i_valid,
   input  logic i_due,
   output logic o_ready,
   output logic o_count_en,
   output logic o_send_marker,
   output logic o_clear
);

   am_state_t state;
   am_state_t state_next;

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         state <= ST_START;
      end
      else
      begin
         state <= state_next;
      end
   end

   always_comb
   begin
      state_next = state;
      case (state)
         ST_START: state_next = ST_DATA;
         ST_DATA:
         begin
            if (i_due)
            begin
               state_next = ST_MARK;
            end
         end
         ST_MARK:  state_next = ST_DATA;
         default:  state_next = ST_START;
      endcase
   end

   // Ready also drops while due is pending so no extra block slips in
   assign o_ready       = (state == ST_DATA) && !i_due;
   assign o_count_en    = i_valid && o_ready;
   assign o_send_marker = (state == ST_START) || (state == ST_MARK);
   assign o_clear       = (state == ST_MARK);

   // Upstream stays held off in a marker slot and the timer restarts right after it
   a_mark_no_ready: assert property (@(posedge i_clock) disable iff (i_reset)
      (state == ST_MARK) |-> !o_ready ##1 !i_due);

endmodule

//--- source/am_period_timer.sv
// Module am_period_timer: counts accepted data blocks and flags a due marker
`timescale 1ns/1ns

module am_period_timer
   import am_ctrl_pkg::*;
(
   input  logic i_clock,
   input  logic i_reset,
   input  logic i_count_en,
   input  logic i_clear,
   output logic o_due
);

   logic [CNT_W-1:0] count;

   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         count <= '0;
      end
      else if (i_clear)
      begin
         count <= '0;
      end
      else if (i_count_en)
      begin
         count <= count + 1'b1;
      end
   end

   assign o_due = (count == CNT_W'(AM_PERIOD));   // Held until the FSM clears

   // The FSM has to stop upstream before the count runs past a full period
   a_count_range: assert property (@(posedge i_clock) disable iff (i_reset)
      count <= CNT_W'(AM_PERIOD));

endmodule

//--- source/bip_calculator.sv
// Module bip_calculator: stage 2 parity accumulator and BIP3/BIP7 insertion
`timescale 1ns/1ns

module bip_calculator
   import pcs_lane_pkg::*;
(
   input  logic               i_clock,
   input  logic               i_reset,
   input  logic               i_valid,
   input  logic [BLOCK_W-1:0] i_block,
   input  logic               i_is_marker,
   output logic               o_valid,
   output logic [BLOCK_W-1:0] o_block
);

   logic [NB_BIP-1:0]  acc;      // Parity since the previous marker, marker included
   logic [BLOCK_W-1:0] marked;   // Marker with both BIP bytes filled in

   // Interleaved parity of one block
   function automatic logic [NB_BIP-1:0] block_parity(input logic [BLOCK_W-1:0] blk);
      logic [NB_BIP-1:0] par;
      par = '0;
      for (int j = 0; j < (BLOCK_W - 2) / NB_BIP; j++)
      begin
         par = par ^ blk[2 + NB_BIP * j +: NB_BIP];
      end
      // Sync header bits fold into lanes 3 and 4
      par[3] = par[3] ^ blk[0];
      par[4] = par[4] ^ blk[1];
      return par;
   endfunction

   always_comb
   begin
      marked = i_block;
      marked[BIP3_POS +: NB_BIP] = acc;
      marked[BIP7_POS +: NB_BIP] = ~acc;
   end

   // ============================================================
   // Accumulator
   // ============================================================
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         acc <= '0;
      end
      else if (i_valid)
      begin
         if (i_is_marker)
         begin
            acc <= block_parity(marked);   // Restart from the completed marker
         end
         else
         begin
            acc <= acc ^ block_parity(i_block);
         end
      end
   end

   // ============================================================
   // Output register
   // ============================================================
   always_ff @(posedge i_clock)
   begin
      if (i_reset)
      begin
         o_valid <= 1'b0;
      end
      else
      begin
         o_valid <= i_valid;
      end
   end

   always_ff @(posedge i_clock)
   begin
      o_block <= i_is_marker ? marked : i_block;
   end

   // The builder only ever hands over markers as control blocks
   a_marker_ctrl: assert property (@(posedge i_clock) disable iff (i_reset)
      i_valid && i_is_marker |-> i_block[1:0] == SH_CTRL);

endmodule

//--- source/pcs_am_inserter.sv
// Module pcs_am_inserter: top level of the lane alignment-marker inserter
`timescale 1ns/1ns

module pcs_am_inserter
   import pcs_lane_pkg::*;
(
   input  logic               i_clock,
   input  logic               i_reset,
   input  logic               i_valid,
   input  logic [BLOCK_W-1:0] i_block,
   output logic               o_ready,
   output logic               o_valid,
   output logic [BLOCK_W-1:0] o_block
);

   logic               count_en;
   logic               clear;
   logic               due;
   logic               send_marker;
   logic               s1_valid;
   logic [BLOCK_W-1:0] s1_block;
   logic               s1_is_marker;

   // ============================================================
   // Marker scheduling
   // ============================================================
   am_period_timer u_timer (
      .i_clock    (i_clock),
      .i_reset    (i_reset),
      .i_count_en (count_en),
      .i_clear    (clear),
      .o_due      (due)
   );

   am_insert_fsm u_fsm (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_valid       (i_valid),
      .i_due         (due),
      .o_ready       (o_ready),
      .o_count_en    (count_en),
      .o_send_marker (send_marker),
      .o_clear       (clear)
   );

   // ============================================================
   // Two stage block pipeline
   // ============================================================
   am_block_builder u_builder (
      .i_clock       (i_clock),
      .i_reset       (i_reset),
      .i_valid       (i_valid),
      .i_ready       (o_ready),
      .i_block       (i_block),
      .i_send_marker (send_marker),
      .o_valid       (s1_valid),
      .o_block       (s1_block),
      .o_is_marker   (s1_is_marker)
   );

   bip_calculator u_bip (
      .i_clock     (i_clock),
      .i_reset     (i_reset),
      .i_valid     (s1_valid),
      .i_block     (s1_block),
      .i_is_marker (s1_is_marker),
      .o_valid     (o_valid),
      .o_block     (o_block)
   );

endmodule

//--- source/pcs_lane_pkg.sv
// Package: block width, sync headers, lane 0 marker and error block encodings, BIP positions
package pcs_lane_pkg;

   // ============================================================
   // Block format
   // ============================================================
   localparam int BLOCK_W = 66;
   localparam int NB_BIP  = 8;

   localparam logic [1:0] SH_DATA = 2'b10;   // Bit 0 clear, bit 1 set
   localparam logic [1:0] SH_CTRL = 2'b01;   // Bit 0 set, bit 1 clear

   // ============================================================
   // Lane 0 alignment marker, M0 sits in the low byte
   // ============================================================
   localparam logic [23:0] AM_M_LOW  = {8'h47, 8'h76, 8'h90};
   localparam logic [23:0] AM_M_HIGH = ~AM_M_LOW;

   localparam int BIP3_POS = 26;
   localparam int BIP7_POS = 58;

   // Marker with both BIP bytes still zero
   localparam logic [BLOCK_W-1:0] AM_TEMPLATE =
      {8'h00, AM_M_HIGH, 8'h00, AM_M_LOW, SH_CTRL};

   // Error control block
   localparam logic [7:0] EBLOCK_TYPE = 8'h1E;
   localparam logic [6:0] ERROR_CODE  = 7'h1E;
   localparam logic [BLOCK_W-1:0] E_BLOCK = {{8{ERROR_CODE}}, EBLOCK_TYPE, SH_CTRL};

endpackage

//--- src.f
source/pcs_lane_pkg.sv
source/am_ctrl_pkg.sv
source/am_period_timer.sv
source/am_insert_fsm.sv
source/am_block_builder.sv
source/bip_calculator.sv
source/pcs_am_inserter.sv
sim/tb_pcs_am_inserter.sv
